// ==== include/frame_consts.svh ====
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// visible raster of a 640x480 VGA mode
`define SCREEN_WIDTH    10'd640
`define SCREEN_HEIGHT   10'd480

// frame buffer holds one byte per visible pixel
`define FRAME_PIXELS    19'd307200

// colour shown outside the visible area
`define BLANK_RED       8'h00
`define BLANK_GREEN     8'hFF
`define BLANK_BLUE      8'hFF

// colour cube steps
// red and green use 3 index bits each, blue only 2
`define CUBE_RG_STEP    8'h20
`define CUBE_B_STEP     8'h40

// lowest and highest index of the colour cube
`define CUBE_FIRST      8'h0A
`define CUBE_LAST       8'hF5

`endif

// ==== hw/frameDisplayPkg.sv ====
`default_nettype none

package frameDisplayPkg;

    // one raster coordinate, wide enough for the full 800x525 timing
    typedef logic [9:0] coordT;

    // position from the raster timing source
    typedef struct packed
    {
        coordT x;
        coordT y;
    } drawPosT;

    typedef logic [18:0] pixelAddrT; // frame-buffer word address
    typedef logic [7:0] colorIndexT; // palette index stored per pixel

    // one colour channel towards the DAC
    typedef logic [7:0] channelT;

    typedef struct packed
    {
        channelT red;
        channelT green;
        channelT blue;
    } rgbT;

endpackage

`default_nettype wire

// ==== hw/frameAddressGen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module frameAddressGen
(
    input  logic                          pixel_clk,
    input  logic                          arstN,
    input  frameDisplayPkg::drawPosT      drawPos,
    output frameDisplayPkg::pixelAddrT    rdAddress,
    output logic                          active
);

    logic inArea;
    frameDisplayPkg::pixelAddrT linearAddr;

    // visible part of the raster
    assign inArea = (drawPos.x < `SCREEN_WIDTH) && (drawPos.y < `SCREEN_HEIGHT);

    // row-major layout, one byte per pixel
    assign linearAddr = frameDisplayPkg::pixelAddrT'(drawPos.y)
                      * frameDisplayPkg::pixelAddrT'(`SCREEN_WIDTH)
                      + frameDisplayPkg::pixelAddrT'(drawPos.x);

    always_ff @(posedge pixel_clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rdAddress <= '0;
            active    <= 1'b0;
        end
        else
        begin
            // park the address at 0 during blanking
            if (inArea)
                rdAddress <= linearAddr;
            else
                rdAddress <= '0;
            active <= inArea; // travels alongside the address
        end
    end

    // the multiply must never leave the frame buffer
    addrInRange: assert property (
        @(posedge pixel_clk) disable iff (!arstN)
        rdAddress < `FRAME_PIXELS
    )
    else
        $error("frame-buffer address %0d out of range", rdAddress);

endmodule

`default_nettype wire

// ==== hw/paletteLookup.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module paletteLookup
(
    input  logic                          pixel_clk,
    input  logic                          arstN,
    input  logic                          active,
    input  frameDisplayPkg::colorIndexT   frameData,
    output frameDisplayPkg::rgbT          pixel
);

    localparam frameDisplayPkg::rgbT blankColor = '{`BLANK_RED, `BLANK_GREEN, `BLANK_BLUE};

    logic activeD; // lines up with frameData
    logic isSystem;
    frameDisplayPkg::rgbT systemColor;
    frameDisplayPkg::rgbT cubeColor;
    frameDisplayPkg::rgbT nextPixel;

    // frame buffer answers one cycle after the address
    always_ff @(posedge pixel_clk or negedge arstN)
    begin
        if (!arstN)
            activeD <= 1'b0;
        else
            activeD <= active;
    end

    // twenty fixed entries at both ends of the palette
    assign isSystem = (frameData < `CUBE_FIRST) || (frameData > `CUBE_LAST);

    always_comb
    begin
        case (frameData)
            8'h00:   systemColor = '{8'h00, 8'h00, 8'h00};
            8'h01:   systemColor = '{8'h80, 8'h00, 8'h00};
            8'h02:   systemColor = '{8'h00, 8'h80, 8'h00};
            8'h03:   systemColor = '{8'h80, 8'h80, 8'h00};
            8'h04:   systemColor = '{8'h00, 8'h00, 8'h80};
            8'h05:   systemColor = '{8'h80, 8'h00, 8'h80};
            8'h06:   systemColor = '{8'h00, 8'h80, 8'h80};
            8'h07:   systemColor = '{8'hC0, 8'hC0, 8'hC0};
            8'h08:   systemColor = '{8'hC0, 8'hDC, 8'hC0}; // money green
            8'h09:   systemColor = '{8'hA6, 8'hCA, 8'hF0}; // sky blue
            8'hF6:   systemColor = '{8'hFF, 8'hFB, 8'hF0}; // cream
            8'hF7:   systemColor = '{8'hA0, 8'hA0, 8'hA4};
            8'hF8:   systemColor = '{8'h80, 8'h80, 8'h80};
            8'hF9:   systemColor = '{8'hFF, 8'h00, 8'h00};
            8'hFA:   systemColor = '{8'h00, 8'hFF, 8'h00};
            8'hFB:   systemColor = '{8'hFF, 8'hFF, 8'h00};
            8'hFC:   systemColor = '{8'h00, 8'h00, 8'hFF};
            8'hFD:   systemColor = '{8'hFF, 8'h00, 8'hFF};
            8'hFE:   systemColor = '{8'h00, 8'hFF, 8'hFF};
            8'hFF:   systemColor = '{8'hFF, 8'hFF, 8'hFF};
            default: systemColor = blankColor; // cube range, not selected
        endcase
    end

    // cube entries follow from the index bits directly
    always_comb
    begin
        cubeColor.red   = frameDisplayPkg::channelT'(frameData[2:0]) * `CUBE_RG_STEP;
        cubeColor.green = frameDisplayPkg::channelT'(frameData[5:3]) * `CUBE_RG_STEP;
        cubeColor.blue  = frameDisplayPkg::channelT'(frameData[7:6]) * `CUBE_B_STEP;
    end

    always_comb
    begin
        if (!activeD)
            nextPixel = blankColor;
        else if (isSystem)
            nextPixel = systemColor;
        else
            nextPixel = cubeColor;
    end

    always_ff @(posedge pixel_clk or negedge arstN)
    begin
        if (!arstN)
            pixel <= blankColor;
        else
            pixel <= nextPixel;
    end

    // blanking wins over whatever the frame buffer returned
    blankOutside: assert property (
        @(posedge pixel_clk) disable iff (!arstN)
        !activeD |=> (pixel == blankColor)
    )
    else
        $error("pixel %06h not blank after inactive cycle", pixel);

endmodule

`default_nettype wire

// ==== hw/frameDisplayer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module frameDisplayer
(
    input  logic                          pixel_clk,
    input  logic                          arstN,
    input  frameDisplayPkg::drawPosT      drawPos,
    input  frameDisplayPkg::colorIndexT   frameData,
    output frameDisplayPkg::pixelAddrT    rdAddress,
    output frameDisplayPkg::rgbT          pixel
);

    logic activeAddr; // visible-area flag, same cycle as rdAddress

    // coordinate to frame-buffer address, 1 cycle
    frameAddressGen i_frameAddressGen
    (
        .pixel_clk (pixel_clk),
        .arstN     (arstN),
        .drawPos   (drawPos),
        .rdAddress (rdAddress),
        .active    (activeAddr)
    );

    // external frame buffer sits between these two, 1 cycle

    // index to colour, 2 cycles from the flag
    paletteLookup i_paletteLookup
    (
        .pixel_clk (pixel_clk),
        .arstN     (arstN),
        .active    (activeAddr),
        .frameData (frameData),
        .pixel     (pixel)
    );

    // end to end, a blanked coordinate shows the blank colour 3 edges later
    blankLatency: assert property (
        @(posedge pixel_clk) disable iff (!arstN)
        !((drawPos.x < `SCREEN_WIDTH) && (drawPos.y < `SCREEN_HEIGHT))
        |-> ##3 (pixel == {`BLANK_RED, `BLANK_GREEN, `BLANK_BLUE})
    )
    else
        $error("blanked coordinate did not give blank pixel after 3 cycles");

endmodule

`default_nettype wire

// ==== verif/tbFrameDisplayer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module tbFrameDisplayer;

    localparam int CYCLE_LIMIT = 5000; // all tests together run about 2650 cycles
    localparam frameDisplayPkg::rgbT blankColor = '{`BLANK_RED, `BLANK_GREEN, `BLANK_BLUE};

    // fixed entries, 0x00-0x09 then 0xF6-0xFF
    localparam logic [23:0] systemTable [20] = '{
        24'h000000, 24'h800000, 24'h008000, 24'h808000, 24'h000080,
        24'h800080, 24'h008080, 24'hC0C0C0, 24'hC0DCC0, 24'hA6CAF0,
        24'hFFFBF0, 24'hA0A0A4, 24'h808080, 24'hFF0000, 24'h00FF00,
        24'hFFFF00, 24'h0000FF, 24'hFF00FF, 24'h00FFFF, 24'hFFFFFF
    };

    logic pixel_clk;
    logic arstN;
    frameDisplayPkg::drawPosT drawPos;
    frameDisplayPkg::colorIndexT frameData = '0;
    frameDisplayPkg::pixelAddrT rdAddress;
    frameDisplayPkg::rgbT pixel;

    frameDisplayPkg::colorIndexT frameMem [0:`FRAME_PIXELS-1];
    frameDisplayPkg::pixelAddrT pendingAddr = '0; // address seen one edge ago
    logic [15:0] lfsrState = 16'd14915;
    int errorCount = 0;
    int cycleCount = 0;
    frameDisplayPkg::drawPosT posQ[$]; // coordinates for the next stream

    frameDisplayer i_frameDisplayer
    (
        .pixel_clk (pixel_clk),
        .arstN     (arstN),
        .drawPos   (drawPos),
        .frameData (frameData),
        .rdAddress (rdAddress),
        .pixel     (pixel)
    );

    initial
    begin
        pixel_clk = 1'b0;
        forever #4 pixel_clk = ~pixel_clk;
    end

    // synchronous frame buffer, data for an address arrives one edge after it is seen
    always @(posedge pixel_clk)
    begin
        #1;
        frameData = frameMem[pendingAddr];
        pendingAddr = rdAddress;
    end

    always @(posedge pixel_clk)
    begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextLfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit)
            lfsrState = lfsrState ^ 16'hB400;
        return outBit;
    endfunction

    function automatic int randomBits(input int width);
        int value;
        value = 0;
        for (int i = 0; i < width; i++)
            value = (value << 1) | int'(nextLfsrBit());
        return value;
    endfunction

    function automatic frameDisplayPkg::colorIndexT fillPattern(input int addr);
        return frameDisplayPkg::colorIndexT'(addr ^ (addr >> 8) ^ (addr >> 16) ^ 'h5A);
    endfunction

    function automatic frameDisplayPkg::drawPosT makePos(input int x, input int y);
        frameDisplayPkg::drawPosT pos;
        pos.x = frameDisplayPkg::coordT'(x);
        pos.y = frameDisplayPkg::coordT'(y);
        return pos;
    endfunction

    function automatic logic inArea(input frameDisplayPkg::drawPosT pos);
        return (int'(pos.x) < 640) && (int'(pos.y) < 480);
    endfunction

    function automatic frameDisplayPkg::pixelAddrT expectedAddr(input frameDisplayPkg::drawPosT pos);
        if (!inArea(pos))
            return '0;
        return frameDisplayPkg::pixelAddrT'(int'(pos.y) * 640 + int'(pos.x));
    endfunction

    function automatic frameDisplayPkg::rgbT refColor(input frameDisplayPkg::colorIndexT idx);
        frameDisplayPkg::rgbT color;
        if (idx <= 8'h09)
            color = systemTable[int'(idx)];
        else if (idx >= 8'hF6)
            color = systemTable[int'(idx) - 'hF6 + 10];
        else
        begin
            color.red   = {idx[2:0], 5'b00000};
            color.green = {idx[5:3], 5'b00000};
            color.blue  = {idx[7:6], 6'b000000}; // only four blue levels
        end
        return color;
    endfunction

    function automatic frameDisplayPkg::rgbT expectedPixel(input frameDisplayPkg::drawPosT pos);
        if (!inArea(pos))
            return blankColor;
        return refColor(frameMem[expectedAddr(pos)]);
    endfunction

    function automatic frameDisplayPkg::colorIndexT systemIndex(input int n);
        if (n < 10)
            return frameDisplayPkg::colorIndexT'(n);
        return frameDisplayPkg::colorIndexT'('hF6 + n - 10);
    endfunction

    task automatic checkAddr(input string name, input frameDisplayPkg::pixelAddrT expected,
                             input frameDisplayPkg::pixelAddrT actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR %s: rdAddress expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkPixel(input string name, input frameDisplayPkg::rgbT expected,
                              input frameDisplayPkg::rgbT actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR %s: pixel expected %06h, actual %06h", name, expected, actual);
        end
    endtask

    // drives posQ back to back, address checked 1 cycle and colour 3 cycles later
    task automatic runStream(input string name);
        frameDisplayPkg::pixelAddrT expAddrQ[$];
        frameDisplayPkg::rgbT expPixelQ[$];
        int n;
        n = posQ.size();
        foreach (posQ[i])
        begin
            expAddrQ.push_back(expectedAddr(posQ[i]));
            expPixelQ.push_back(expectedPixel(posQ[i]));
        end
        for (int i = 0; i < n + 3; i++)
        begin
            @(posedge pixel_clk);
            #1;
            drawPos = (i < n) ? posQ[i] : makePos(700, 500); // idle in blanking
            if (i >= 1 && i <= n)
                checkAddr(name, expAddrQ[i - 1], rdAddress);
            if (i >= 3)
                checkPixel(name, expPixelQ[i - 3], pixel);
        end
        posQ.delete();
    endtask

    task automatic testReset();
        drawPos = makePos(5, 7); // in area, must not leak through reset
        repeat (4)
        begin
            @(posedge pixel_clk);
            #1;
            checkAddr("testReset", '0, rdAddress);
            checkPixel("testReset", blankColor, pixel);
        end
        arstN = 1'b1;
        drawPos = makePos(700, 500);
        // both active flags leave reset low, so frame data must not show yet
        repeat (2)
        begin
            @(posedge pixel_clk);
            #1;
            checkAddr("testReset", '0, rdAddress);
            checkPixel("testReset", blankColor, pixel);
        end
    endtask

    task automatic testAddress();
        for (int i = 0; i < 64; i++)
            posQ.push_back(makePos(randomBits(10) % 640, randomBits(9) % 480));
        runStream("testAddress");
    endtask

    task automatic testBlanking();
        for (int i = 0; i < 45; i++)
        begin
            case (i % 3)
                0: posQ.push_back(makePos(640 + randomBits(8) % 160, randomBits(9) % 480));
                1: posQ.push_back(makePos(randomBits(10) % 640, 480 + randomBits(6) % 45));
                default: posQ.push_back(makePos(640 + randomBits(8) % 160, 480 + randomBits(6) % 45));
            endcase
        end
        runStream("testBlanking");
    endtask

    task automatic testSystemColors();
        frameDisplayPkg::drawPosT pos;
        for (int i = 0; i < 20; i++)
        begin
            pos = makePos(37 + i * 29, 120 + i);
            frameMem[expectedAddr(pos)] = systemIndex(i);
            posQ.push_back(pos);
        end
        runStream("testSystemColors");
    endtask

    task automatic testColorCube();
        frameDisplayPkg::drawPosT pos;
        for (int i = 0; i < 100; i++)
        begin
            pos = makePos(i * 6, 300);
            frameMem[expectedAddr(pos)] = frameDisplayPkg::colorIndexT'('h0A + randomBits(8) % 236);
            posQ.push_back(pos);
        end
        runStream("testColorCube");
    endtask

    // last two visible lines and the first blank one, each with its horizontal blanking
    task automatic testStreaming();
        frameDisplayPkg::drawPosT pos;
        for (int y = 478; y <= 480; y++)
        begin
            for (int x = 0; x < 800; x++)
            begin
                pos = makePos(x, y);
                if (inArea(pos))
                    frameMem[expectedAddr(pos)] = frameDisplayPkg::colorIndexT'(randomBits(8));
                posQ.push_back(pos);
            end
        end
        runStream("testStreaming");
    endtask

    initial
    begin
        arstN = 1'b0;
        drawPos = '0;
        for (int a = 0; a < `FRAME_PIXELS; a++)
            frameMem[a] = fillPattern(a);

        testReset();
        testAddress();
        testBlanking();
        testSystemColors();
        testColorCube();
        testStreaming();

        $display("error count: %0d", errorCount);
        if (errorCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hw/frameDisplayPkg.sv
hw/frameAddressGen.sv
hw/paletteLookup.sv
hw/frameDisplayer.sv
verif/tbFrameDisplayer.sv

// ==== Makefile ====
# Verilator flow for the frame display back end
TOP := tbFrameDisplayer

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

# the log is searched for the fail message, a crashed run also fails
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
